//--- program.hex
// One 32-bit instruction word per line, loaded from address 0 upward
// Results go to IO slots at 0x400000, slot 62 marks a wrong path, slot 63 ends the run
00400FB7 // lui   x31,0x400
FFB00093 // addi  x1,x0,-5
00300113 // addi  x2,x0,3
11223237 // lui   x4,0x11223
34420213 // addi  x4,x4,0x344
70000293 // addi  x5,x0,0x700
002081B3 // add   x3,x1,x2
003FA023 // sw    slot 0
402081B3 // sub
003FA223 // sw    slot 1
002091B3 // sll
003FA423 // sw    slot 2
0020A1B3 // slt
003FA623 // sw    slot 3
0020B1B3 // sltu
003FA823 // sw    slot 4
0020C1B3 // xor
003FAA23 // sw    slot 5
0020D1B3 // srl
003FAC23 // sw    slot 6
4020D1B3 // sra
003FAE23 // sw    slot 7
0020E1B3 // or
023FA023 // sw    slot 8
0020F1B3 // and
023FA223 // sw    slot 9
06408193 // addi  x3,x1,100
023FA423 // sw    slot 10
FFC0A193 // slti  x3,x1,-4
023FA623 // sw    slot 11
FFF13193 // sltiu x3,x2,-1
023FA823 // sw    slot 12
0FF0F193 // andi  x3,x1,0xff
023FAA23 // sw    slot 13
00411193 // slli  x3,x2,4
023FAC23 // sw    slot 14
4010D193 // srai  x3,x1,1
023FAE23 // sw    slot 15
00428023 // sb    x4,0(x5)
002280A3 // sb    x2,1(x5)
00128123 // sb    x1,2(x5)
004281A3 // sb    x4,3(x5)
00429223 // sh    x4,4(x5)
00129323 // sh    x1,6(x5)
0002A183 // lw    x3,0(x5)
043FA023 // sw    slot 16
0042A183 // lw    x3,4(x5)
043FA223 // sw    slot 17
00028183 // lb    x3,0(x5)
043FA423 // sw    slot 18
00128183 // lb    x3,1(x5)
043FA623 // sw    slot 19
00228183 // lb    x3,2(x5)
043FA823 // sw    slot 20
00328183 // lb    x3,3(x5)
043FAA23 // sw    slot 21
0022C183 // lbu   x3,2(x5)
043FAC23 // sw    slot 22
00429183 // lh    x3,4(x5)
043FAE23 // sw    slot 23
00629183 // lh    x3,6(x5)
063FA023 // sw    slot 24
0062D183 // lhu   x3,6(x5)
063FA223 // sw    slot 25
ABCDE1B7 // lui   x3,0xabcde
063FA423 // sw    slot 26
00001197 // auipc x3,1 at 0x108
063FA623 // sw    slot 27
008001EF // jal   x3,+8 at 0x110
0E0FAC23 // sw    wrong path
063FA823 // sw    slot 28
00000517 // auipc x10,0 at 0x11c
00C501E7 // jalr  x3,12(x10)
0E0FAC23 // sw    wrong path
063FAA23 // sw    slot 29
00210463 // beq   x2,x2 taken
0E0FAC23 // sw    wrong path
00209463 // bne   x1,x2 taken
0E0FAC23 // sw    wrong path
0020C463 // blt   x1,x2 taken
0E0FAC23 // sw    wrong path
00115463 // bge   x2,x1 taken
0E0FAC23 // sw    wrong path
00116463 // bltu  x2,x1 taken
0E0FAC23 // sw    wrong path
0020F463 // bgeu  x1,x2 taken
0E0FAC23 // sw    wrong path
00208E63 // beq   x1,x2 not taken
00211C63 // bne   x2,x2 not taken
00114A63 // blt   x2,x1 not taken
0020D863 // bge   x1,x2 not taken
0020E663 // bltu  x1,x2 not taken
00117463 // bgeu  x2,x1 not taken
0080006F // jal   x0,+8
0E0FAC23 // sw    wrong path
0E2FAE23 // sw    x2 to done slot
0000006F // jal   x0,0

//--- flist.f
rvPkg.sv
rvDecoder.sv
rvRegFile.sv
rvAlu.sv
rvControl.sv
rvMemAlign.sv
rvCore.sv
tbCore.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator, fail if the log reports errors
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCore -f flist.f
./obj_dir/VtbCore > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0

//--- tbCore.sv
// Testbench for the RV32I core that runs program.hex against a busy-stretched memory and checks slots
`timescale 1ns/1ps

module tbCore;

   // **************************************************
   // Test constants
   localparam int unsigned memWords      = 1024;       // 4 KB of RAM
   localparam int unsigned programWords  = 97;         // Length of program.hex
   localparam int unsigned timeoutCycles = programWords * 40;
   localparam int unsigned wrongSlot     = 62;         // Any write here is a wrong path
   localparam int unsigned doneSlot      = 63;
   localparam int unsigned resultCount   = 30;
   localparam logic [31:0] opA = 32'hFFFF_FFFB;        // x1 holds -5
   localparam logic [31:0] opB = 32'h0000_0003;        // x2
   localparam logic [31:0] opC = 32'h1122_3344;        // x4 store pattern

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;

   logic [31:0] mem [memWords];
   logic [31:0] ioData [64];     // IO result window selected by address bit 22
   logic        ioWritten [64];
   logic        doneSeen;
   logic        readPending;     // Strobe issued, data not yet taken
   logic        ioPending;       // IO store waiting on the busy lines
   int          errorCount;

   rvCore u_dut (.*);

   always #20 clk = ~clk;

   // **************************************************
   // Memory model
   always @(posedge clk) begin
      if (memRstrb && !memAddr[22]) begin
         memRdata <= mem[memAddr[11:2]];  // Held until the next strobe
      end
      if (memWmask != 4'b0000) begin
         if (memAddr[22]) begin
            writeTarget: assert (memAddr[7:2] != 6'(wrongSlot)) else begin
               errorCount++;
               $display("FAILED %0t: wrong-path marker written", $time);
            end
            ioData[memAddr[7:2]]    <= memWdata;
            ioWritten[memAddr[7:2]] <= 1'b1;
            if (memAddr[7:2] == 6'(doneSlot)) begin
               doneSeen <= 1'b1;
            end
         end else begin
            for (int i = 0; i < 4; i++) begin
               if (memWmask[i]) begin
                  mem[memAddr[11:2]][8*i +: 8] <= memWdata[8*i +: 8];
               end
            end
         end
      end
   end

   // Random stretching on both busy lines from one seeded stream
   initial begin
      void'($urandom(32'h552b_8de3));
      forever begin
         @(posedge clk);
         memRbusy <= (($urandom() % 4) == 0);
         memWbusy <= (($urandom() % 4) == 0);
      end
   end

   // Tracks when the core must stay quiet on the bus
   always @(posedge clk) begin
      if (!reset) begin
         readPending <= 1'b0;
         ioPending   <= 1'b0;
      end else begin
         if (memRstrb) readPending <= 1'b1;
         else if (!memRbusy) readPending <= 1'b0;
         if (memWmask != 4'b0000 && memAddr[22]) ioPending <= 1'b1;
         else if (!memRbusy && !memWbusy) ioPending <= 1'b0;
      end
   end

   // **************************************************
   // Bus protocol checks
   resetQuiet: assert property (@(posedge clk) !reset |-> !memRstrb && memWmask == 4'b0000)
      else begin
         errorCount++;
         $display("Bus strobe or write mask active during reset at %0t", $time);
      end

   waitQuiet: assert property (@(posedge clk) disable iff (!reset)
                               (readPending || ioPending) |-> !memRstrb && memWmask == 4'b0000)
      else begin
         errorCount++;
         $display("Bus strobe or write mask active while the core waits at %0t", $time);
      end

   addrPadding: assert property (@(posedge clk) disable iff (!reset)
                                 (memRstrb || memWmask != 4'b0000) |-> memAddr[31:24] == 8'h00)
      else begin
         errorCount++;
         $display("FAILED %0t: bus address %h not zero above bit 23", $time, memAddr);
      end

   function automatic logic [31:0] signExtendByte(input logic [7:0] value);
      return {{24{value[7]}}, value};
   endfunction

   function automatic logic [31:0] signExtendHalf(input logic [15:0] value);
      return {{16{value[15]}}, value};
   endfunction

   task automatic checkSlot(input int slot, input logic [31:0] expected, input string what);
      if (!ioWritten[slot]) begin
         errorCount++;
         $display("Result slot %0d for %s was never written", slot, what);
      end else begin
         slotValue: assert (ioData[slot] === expected) else begin
            errorCount++;
            $display("FAILED %0t: %s slot %0d got %h, expected %h",
                     $time, what, slot, ioData[slot], expected);
         end
      end
   endtask

   // Watchdog at about forty cycles per program word
   initial begin
      repeat (timeoutCycles) @(posedge clk);
      errorCount++;
      $display("Timeout, the program never reached its done store");
      $display("Run finished with %0d errors", errorCount);
      $display("ERRORS FOUND");
      $finish;
   end

   // **************************************************
   // Main sequence
   initial begin
      clk        = 1'b0;
      reset      = 1'b0;
      memRdata   = '0;
      memRbusy   = 1'b0;
      memWbusy   = 1'b0;
      doneSeen   = 1'b0;
      errorCount = 0;
      for (int i = 0; i < 64; i++) begin
         ioWritten[i] = 1'b0;
         ioData[i]    = '0;
      end
      for (int i = 0; i < memWords; i++) begin
         mem[i] = 32'h5A5A_5A5A ^ {i[15:0], i[15:0]};
      end
      $readmemh("program.hex", mem);

      repeat (4) @(posedge clk);
      reset <= 1'b1;
      wait (doneSeen);
      repeat (2) @(posedge clk);

      checkSlot(0, opA + opB, "ADD");
      checkSlot(1, opA - opB, "SUB");
      checkSlot(2, opA << opB[4:0], "SLL");
      checkSlot(3, {31'b0, $signed(opA) < $signed(opB)}, "SLT");
      checkSlot(4, {31'b0, opA < opB}, "SLTU");
      checkSlot(5, opA ^ opB, "XOR");
      checkSlot(6, opA >> opB[4:0], "SRL");
      checkSlot(7, 32'($signed(opA) >>> opB[4:0]), "SRA");
      checkSlot(8, opA | opB, "OR");
      checkSlot(9, opA & opB, "AND");
      checkSlot(10, opA + 32'd100, "ADDI");
      checkSlot(11, {31'b0, $signed(opA) < -32'sd4}, "SLTI");
      checkSlot(12, {31'b0, opB < 32'hFFFF_FFFF}, "SLTIU");
      checkSlot(13, opA & 32'h0000_00FF, "ANDI");
      checkSlot(14, opB << 4, "SLLI");
      checkSlot(15, 32'($signed(opA) >>> 1), "SRAI");
      checkSlot(16, {opC[7:0], opA[7:0], opB[7:0], opC[7:0]}, "SB lanes");
      checkSlot(17, {opA[15:0], opC[15:0]}, "SH lanes");
      checkSlot(18, signExtendByte(opC[7:0]), "LB offset 0");
      checkSlot(19, signExtendByte(opB[7:0]), "LB offset 1");
      checkSlot(20, signExtendByte(opA[7:0]), "LB offset 2");
      checkSlot(21, signExtendByte(opC[7:0]), "LB offset 3");
      checkSlot(22, {24'b0, opA[7:0]}, "LBU offset 2");
      checkSlot(23, signExtendHalf(opC[15:0]), "LH offset 0");
      checkSlot(24, signExtendHalf(opA[15:0]), "LH offset 2");
      checkSlot(25, {16'b0, opA[15:0]}, "LHU offset 2");
      checkSlot(26, 32'hABCD_E000, "LUI");
      checkSlot(27, 32'd264 + 32'h0000_1000, "AUIPC");
      checkSlot(28, 32'd272 + 32'd4, "JAL link");
      checkSlot(29, 32'd288 + 32'd4, "JALR link");

      $display("Run finished with %0d errors over %0d result slots", errorCount, resultCount);
      if (errorCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- rvCore.sv
// RV32I core top level, connects decoder, registers, ALU, sequencer and memory alignment to the bus
`timescale 1ns/1ps

module rvCore (
   input  logic                   clk,
   input  logic                   reset,
   output logic [rvPkg::xlen-1:0] memAddr,   // Zero above bit 23
   output logic [rvPkg::xlen-1:0] memWdata,
   output logic [3:0]             memWmask,
   input  logic [rvPkg::xlen-1:0] memRdata,  // Instructions and load data
   output logic                   memRstrb,
   input  logic                   memRbusy,
   input  logic                   memWbusy
);
   import rvPkg::*;

   // Decoder outputs
   logic                 isLoad;
   logic                 isStore;
   logic                 isAluImm;
   logic                 isAluReg;
   logic                 isLui;
   logic                 isAuipc;
   logic                 isBranch;
   logic                 isJal;
   logic                 isJalr;
   logic [4:0]           rd;
   logic [2:0]           funct3;
   logic                 subtract;
   logic                 arithShift;
   logic [xlen-1:0]      immI;
   logic [xlen-1:0]      immS;
   logic [xlen-1:0]      immB;
   logic [xlen-1:0]      immU;
   logic [xlen-1:0]      immJ;

   // Datapath
   logic [xlen-1:0]      rs1Data;
   logic [xlen-1:0]      rs2Data;
   logic [xlen-1:0]      aluIn2;
   logic [xlen-1:0]      aluOut;
   logic                 predicate;
   logic [xlen-1:0]      loadData;
   logic [3:0]           storeMask;

   // Sequencer outputs
   logic                 latchInstr;
   logic                 aluStart;
   logic                 writeBack;
   logic [xlen-1:0]      writeData;
   logic [addrWidth-1:0] addrReg;
   logic                 storeActive;

   assign aluIn2   = (isAluReg | isBranch) ? rs2Data : immI;
   assign memWmask = storeMask & {4{storeActive}};  // Mask lives one cycle
   assign memAddr  = xlen'(addrReg);

   rvDecoder uDecoder (.*);

   rvRegFile uRegFile (
      .clk,
      .readEn    (latchInstr),
      .rs1Id     (memRdata[19:15]),  // Same cycle as the instruction latch
      .rs2Id     (memRdata[24:20]),
      .rs1Data,
      .rs2Data,
      .writeEn   (writeBack),
      .rd,
      .writeData
   );

   rvAlu uAlu (
      .clk,
      .start      (aluStart),
      .isAlu      (isAluImm | isAluReg),
      .funct3,
      .subtract,
      .arithShift,
      .in1        (rs1Data),
      .in2        (aluIn2),
      .aluOut,
      .predicate
   );

   rvControl uControl (.*);

   rvMemAlign uMemAlign (
      .byteOffset (addrReg[1:0]),
      .funct3,
      .memRdata,
      .rs2Data,
      .loadData,
      .memWdata,
      .storeMask
   );

endmodule

//--- rvMemAlign.sv
// Load and store lane alignment for byte, halfword and word accesses on the 32-bit bus
`timescale 1ns/1ps

module rvMemAlign (
   input  logic [1:0]             byteOffset,  // Low address bits
   input  logic [2:0]             funct3,      // Size in 1:0, unsigned in 2
   input  logic [rvPkg::xlen-1:0] memRdata,
   input  logic [rvPkg::xlen-1:0] rs2Data,
   output logic [rvPkg::xlen-1:0] loadData,
   output logic [rvPkg::xlen-1:0] memWdata,
   output logic [3:0]             storeMask    // Gated with the store state outside
);
   import rvPkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // **************************************************
   // Load side
   assign loadHalf = byteOffset[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = byteOffset[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Store side, low bytes copied into every lane they may land in
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = byteOffset[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = byteOffset[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = byteOffset[0] ? rs2Data[7:0] :
                            byteOffset[1] ? rs2Data[15:8] : rs2Data[31:24];

   // One lane for a byte, a pair for a halfword, all four for a word
   assign storeMask = byteAccess ? (4'b0001 << byteOffset) :
                      halfAccess ? (byteOffset[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

endmodule

//--- rvControl.sv
// One-hot sequencer with PC, address register, address adder and register write-back select
`timescale 1ns/1ps

module rvControl (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        isLoad,
   input  logic                        isStore,
   input  logic                        isAluImm,
   input  logic                        isAluReg,
   input  logic                        isLui,
   input  logic                        isAuipc,
   input  logic                        isBranch,
   input  logic                        isJal,
   input  logic                        isJalr,
   input  logic [rvPkg::xlen-1:0]      immI,
   input  logic [rvPkg::xlen-1:0]      immS,
   input  logic [rvPkg::xlen-1:0]      immB,
   input  logic [rvPkg::xlen-1:0]      immU,
   input  logic [rvPkg::xlen-1:0]      immJ,
   input  logic [rvPkg::xlen-1:0]      rs1Data,
   input  logic [rvPkg::xlen-1:0]      aluOut,
   input  logic                        predicate,
   input  logic [rvPkg::xlen-1:0]      loadData,
   input  logic                        memRbusy,
   input  logic                        memWbusy,
   output logic                        latchInstr,
   output logic                        aluStart,
   output logic                        writeBack,
   output logic [rvPkg::xlen-1:0]      writeData,
   output logic [rvPkg::addrWidth-1:0] addrReg,     // Drives the bus address
   output logic                        memRstrb,
   output logic                        storeActive
);
   import rvPkg::*;

   logic [stateCount-1:0] state;
   logic [addrWidth-1:0]  pc;
   logic [addrWidth-1:0]  pcPlus4;
   logic [addrWidth-1:0]  adderIn1;
   logic [addrWidth-1:0]  adderIn2;
   logic [addrWidth-1:0]  adderOut;   // PC+imm or rs1+imm
   logic                  jump;       // JAL, JALR or taken branch
   logic                  ioAddr;

   assign pcPlus4 = pc + addrWidth'(4);
   assign jump    = isJal | isJalr | (isBranch & predicate);
   assign ioAddr  = addrReg[ioSelectHigh] | addrReg[ioSelectLow];

   // **************************************************
   // Address adder registered in ADDR_AND_ALU
   assign adderIn1 = (isLoad | isStore | isJalr) ? rs1Data[addrWidth-1:0] : pc;
   assign adderIn2 = isJal    ? immJ[addrWidth-1:0] :
                     isAuipc  ? immU[addrWidth-1:0] :
                     isStore  ? immS[addrWidth-1:0] :
                     isBranch ? immB[addrWidth-1:0] :
                                immI[addrWidth-1:0];  // Load, JALR

   always_ff @(posedge clk) begin
      if (state[addrAluBit]) begin
         adderOut <= adderIn1 + adderIn2;
      end
   end

   // Decoded flags select exactly one source
   assign writeData = ({xlen{isLui}}            & immU)
                    | ({xlen{isAluImm | isAluReg}} & aluOut)
                    | ({xlen{isAuipc}}          & xlen'(adderOut))
                    | ({xlen{isJal | isJalr}}   & xlen'(pcPlus4))   // Link
                    | ({xlen{isLoad}}           & loadData);

   // Strobes straight from the state bits
   assign latchInstr  = state[waitInstrBit] & !memRbusy;
   assign aluStart    = state[addrAluBit];
   assign memRstrb    = state[fetchInstrBit] | state[loadBit];
   assign storeActive = state[storeBit];
   assign writeBack   = !(isBranch | isStore) & (state[executeBit] | state[waitMemBit]);

   // **************************************************
   // State sequence
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= oneHot(waitMemBit);  // Start by waiting out any busy bus
         pc    <= resetAddr;
      end else begin
         case (1'b1)
            state[fetchInstrBit]: state <= oneHot(waitInstrBit);
            state[waitInstrBit]: begin
               if (!memRbusy) begin
                  state <= oneHot(fetchRegsBit);
               end
            end
            state[fetchRegsBit]: state <= oneHot(addrAluBit);
            state[addrAluBit]:   state <= oneHot(executeBit);
            state[executeBit]: begin
               pc      <= jump ? adderOut : pcPlus4;
               addrReg <= (isLoad | isStore | jump) ? adderOut : pcPlus4;
               state   <= isLoad  ? oneHot(loadBit) :
                          isStore ? oneHot(storeBit) :
                                    oneHot(fetchInstrBit);
            end
            state[loadBit]: state <= oneHot(waitMemBit);
            state[storeBit]: begin
               addrReg <= pc;  // Mask already used the store address
               state   <= ioAddr ? oneHot(waitMemBit) : oneHot(fetchInstrBit);
            end
            state[waitMemBit]: begin
               if (!memRbusy && !memWbusy) begin
                  addrReg <= pc;
                  state   <= oneHot(fetchInstrBit);
               end
            end
            default: state <= oneHot(waitMemBit);
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state));

   // Read strobe is a single-cycle pulse
   assert property (@(posedge clk) disable iff (!reset) memRstrb |=> !memRstrb);

endmodule

//--- rvAlu.sv
// Integer ALU and branch comparator with result and predicate registered one cycle after start
`timescale 1ns/1ps

module rvAlu (
   input  logic                   clk,
   input  logic                   start,       // One cycle pulse from ADDR_AND_ALU
   input  logic                   isAlu,       // Low means branch compare
   input  logic [2:0]             funct3,
   input  logic                   subtract,
   input  logic                   arithShift,
   input  logic [rvPkg::xlen-1:0] in1,
   input  logic [rvPkg::xlen-1:0] in2,
   output logic [rvPkg::xlen-1:0] aluOut,
   output logic                   predicate
);
   import rvPkg::*;

   logic [xlen-1:0]        plus;
   logic [xlen:0]          minus;       // Carry out gives the unsigned compare
   logic                   lessSigned;
   logic                   lessUnsigned;
   logic                   equal;
   logic [xlen-1:0]        in1Rev;
   logic [xlen-1:0]        shifterIn;
   logic signed [xlen:0]   shiftWide;
   logic [xlen-1:0]        shifter;
   logic [xlen-1:0]        leftShift;

   assign plus  = in1 + in2;
   assign minus = {1'b1, ~in2} + {1'b0, in1} + {{xlen{1'b0}}, 1'b1};

   // Compares all come from the one subtract
   assign lessUnsigned = minus[xlen];
   assign lessSigned   = (in1[xlen-1] ^ in2[xlen-1]) ? in1[xlen-1] : minus[xlen];
   assign equal        = (minus[xlen-1:0] == '0);

   // **************************************************
   // One right shifter with input and output reversed for SLL
   assign in1Rev    = {<<{in1}};
   assign shifterIn = funct3[2] ? in1 : in1Rev;
   assign shiftWide = $signed({arithShift & in1[xlen-1], shifterIn}) >>> in2[4:0];
   assign shifter   = shiftWide[xlen-1:0];
   assign leftShift = {<<{shifter}};

   always_ff @(posedge clk) begin
      if (start && isAlu) begin
         case (funct3)
            3'b000: aluOut <= subtract ? minus[xlen-1:0] : plus;  // ADD, SUB
            3'b001: aluOut <= leftShift;                          // SLL
            3'b010: aluOut <= {{(xlen-1){1'b0}}, lessSigned};     // SLT
            3'b011: aluOut <= {{(xlen-1){1'b0}}, lessUnsigned};   // SLTU
            3'b100: aluOut <= in1 ^ in2;
            3'b101: aluOut <= shifter;                            // SRL, SRA
            3'b110: aluOut <= in1 | in2;
            3'b111: aluOut <= in1 & in2;
         endcase
      end
   end

   // Branch test latched so EXECUTE sees a flop rather than the comparator
   always_ff @(posedge clk) begin
      if (start && !isAlu) begin
         case (funct3)
            3'b000:  predicate <= equal;          // BEQ
            3'b001:  predicate <= !equal;         // BNE
            3'b100:  predicate <= lessSigned;     // BLT
            3'b101:  predicate <= !lessSigned;    // BGE
            3'b110:  predicate <= lessUnsigned;   // BLTU
            3'b111:  predicate <= !lessUnsigned;  // BGEU
            default: predicate <= predicate;
         endcase
      end
   end

endmodule

//--- rvRegFile.sv
// Integer register file with both read ports registered on readEn and one write port that skips x0
`timescale 1ns/1ps

module rvRegFile (
   input  logic                   clk,
   input  logic                   readEn,
   input  logic [4:0]             rs1Id,
   input  logic [4:0]             rs2Id,
   output logic [rvPkg::xlen-1:0] rs1Data,
   output logic [rvPkg::xlen-1:0] rs2Data,
   input  logic                   writeEn,
   input  logic [4:0]             rd,
   input  logic [rvPkg::xlen-1:0] writeData
);
   import rvPkg::*;

   logic [xlen-1:0] regs [regCount];  // Entry 0 is never written

   always_ff @(posedge clk) begin
      if (writeEn && rd != 5'd0) begin
         regs[rd] <= writeData;
      end
      if (readEn) begin  // Ids come straight off the fetch bus
         rs1Data <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2Data <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

   // No write-to-read bypass exists, so a write never falls in the read cycle
   assert property (@(posedge clk) writeEn |-> !readEn);

endmodule

//--- rvDecoder.sv
// Instruction latch and decoder, turns the fetched word into class flags, fields and immediates
`timescale 1ns/1ps

module rvDecoder (
   input  logic                   clk,
   input  logic                   latchInstr,  // Fetched word valid on memRdata
   input  logic [rvPkg::xlen-1:0] memRdata,
   output logic                   isLoad,
   output logic                   isStore,
   output logic                   isAluImm,
   output logic                   isAluReg,
   output logic                   isLui,
   output logic                   isAuipc,
   output logic                   isBranch,
   output logic                   isJal,
   output logic                   isJalr,
   output logic [4:0]             rd,
   output logic [2:0]             funct3,
   output logic                   subtract,    // SUB rather than ADD
   output logic                   arithShift,  // SRA rather than SRL
   output logic [rvPkg::xlen-1:0] immI,
   output logic [rvPkg::xlen-1:0] immS,
   output logic [rvPkg::xlen-1:0] immB,
   output logic [rvPkg::xlen-1:0] immU,
   output logic [rvPkg::xlen-1:0] immJ
);
   import rvPkg::*;

   instrWord_u instr;  // Current instruction, held for its whole run

   always_ff @(posedge clk) begin
      if (latchInstr) begin
         instr <= instrWord_u'(memRdata);
      end
   end

   // Opcode class, every layout shares the low bits
   assign isLoad   = (instr.r.opClass == opLoad);
   assign isStore  = (instr.r.opClass == opStore);
   assign isAluImm = (instr.r.opClass == opAluImm);
   assign isAluReg = (instr.r.opClass == opAluReg);
   assign isLui    = (instr.r.opClass == opLui);
   assign isAuipc  = (instr.r.opClass == opAuipc);
   assign isBranch = (instr.r.opClass == opBranch);
   assign isJal    = (instr.r.opClass == opJal);
   assign isJalr   = (instr.r.opClass == opJalr);

   assign rd     = instr.r.rd;
   assign funct3 = instr.r.funct3;

   // ADDI has an immediate in bit 30, so only the reg-reg form subtracts
   assign subtract   = isAluReg & instr.r.funct7[5];
   assign arithShift = instr.r.funct7[5];  // Same bit for SRA and SRAI

   // **************************************************
   // Sign-extended immediates, one per format
   assign immI = {{20{instr.i.imm[11]}}, instr.i.imm};
   assign immS = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
   assign immB = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.immHi, instr.b.immLo, 1'b0};
   assign immU = {instr.u.imm, 12'b0};
   assign immJ = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.immHi,
                  instr.j.imm11, instr.j.immLo, 1'b0};

endmodule

//--- rvPkg.sv
// Shared widths, opcode classes, FSM state indices and instruction layouts, imported by every core block
package rvPkg;

   // **************************************************
   // Widths and fixed addresses
   localparam int unsigned xlen      = 32;          // Data word width
   localparam int unsigned addrWidth = 24;          // Internal address width
   localparam int unsigned regCount  = 32;          // x0 to x31
   localparam logic [addrWidth-1:0] resetAddr = '0; // First fetch after reset

   // Either of these address bits set means mapped IO
   localparam int unsigned ioSelectHigh = 23;
   localparam int unsigned ioSelectLow  = 22;

   // **************************************************
   // Opcode classes, instruction bits 6:2
   localparam logic [4:0] opLoad   = 5'b00000; // rd <- mem[rs1+immI]
   localparam logic [4:0] opAluImm = 5'b00100; // rd <- rs1 op immI
   localparam logic [4:0] opAuipc  = 5'b00101; // rd <- PC + immU
   localparam logic [4:0] opStore  = 5'b01000; // mem[rs1+immS] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100; // rd <- rs1 op rs2
   localparam logic [4:0] opLui    = 5'b01101; // rd <- immU
   localparam logic [4:0] opBranch = 5'b11000; // PC <- PC + immB if taken
   localparam logic [4:0] opJalr   = 5'b11001; // rd <- PC+4, PC <- rs1 + immI
   localparam logic [4:0] opJal    = 5'b11011; // rd <- PC+4, PC <- PC + immJ

   // **************************************************
   // One-hot sequencer, one bit per state
   localparam int unsigned stateCount    = 8;
   localparam int unsigned fetchInstrBit = 0; // Read strobe, instruction in flight
   localparam int unsigned waitInstrBit  = 1; // Latch instruction once not busy
   localparam int unsigned fetchRegsBit  = 2; // Register values in flight
   localparam int unsigned executeBit    = 3; // PC update and branching point
   localparam int unsigned loadBit       = 4; // Read strobe, data in flight
   localparam int unsigned waitMemBit    = 5; // Wait for load data or IO write
   localparam int unsigned storeBit      = 6; // Write mask active
   localparam int unsigned addrAluBit    = 7; // Address adder and ALU register

   function automatic logic [stateCount-1:0] oneHot(input int unsigned idx);
      oneHot      = '0;
      oneHot[idx] = 1'b1;
   endfunction

   // **************************************************
   // Instruction field layouts, MSB first
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [4:0] opClass;
      logic [1:0] quadrant;
   } rFmt_s;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [4:0]  opClass;
      logic [1:0]  quadrant;
   } iFmt_s;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [4:0] opClass;
      logic [1:0] quadrant;
   } sFmt_s;

   typedef struct packed {
      logic       imm12;
      logic [5:0] immHi;   // Bits 10:5
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] immLo;   // Bits 4:1
      logic       imm11;
      logic [4:0] opClass;
      logic [1:0] quadrant;
   } bFmt_s;

   typedef struct packed {
      logic [19:0] imm;    // Bits 31:12
      logic [4:0]  rd;
      logic [4:0]  opClass;
      logic [1:0]  quadrant;
   } uFmt_s;

   typedef struct packed {
      logic       imm20;
      logic [9:0] immLo;   // Bits 10:1
      logic       imm11;
      logic [7:0] immHi;   // Bits 19:12
      logic [4:0] rd;
      logic [4:0] opClass;
      logic [1:0] quadrant;
   } jFmt_s;

   // One stored word, read through whichever layout the opcode implies
   typedef union packed {
      rFmt_s r;
      iFmt_s i;
      sFmt_s s;
      bFmt_s b;
      uFmt_s u;
      jFmt_s j;
   } instrWord_u;

endpackage
